// ==== hdl/boot_rom.hex ====
// boot ROM image, one 32-bit word per line, word index 0 first
B0B00000
B0B10203
B0B20406
B0B30609
B0B4080C
B0B50A0F
B0B60C12
B0B70E15
B0B81018
B0B9121B
B0BA141E
B0BB1621
B0BC1824
B0BD1A27
B0BE1C2A
B0BF1E2D
B0C02030
B0C12233
B0C22436
B0C32639
B0C4283C
B0C52A3F
B0C62C42
B0C72E45
B0C83048
B0C9324B
B0CA344E
B0CB3651
B0CC3854
B0CD3A57
B0CE3C5A
B0CF3E5D

// ==== compile.f ====
hdl/mem_map_pkg.sv
hdl/mem_access_pkg.sv
hdl/sram_bank.sv
hdl/addr_decode_stage.sv
hdl/excl_monitor.sv
hdl/mem_bank_stage.sv
hdl/mem_subsys.sv
sim/mem_subsys_assertions.sv
sim/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f compile.f --top-module mem_subsys_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion errors so the testbench can report them
"$OBJ"/Vmem_subsys_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0

// ==== sim/mem_subsys_tb.sv ====
`default_nettype none

module mem_subsys_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import mem_map_pkg::*;
    import mem_access_pkg::*;

    localparam int MAX_ENTRIES = 40;
    localparam int CLK_PERIOD  = 10;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    logic [ADDR_W-1:0] req_addr;
    logic              req_write;
    logic              req_ex;
    logic [STRB_W-1:0] req_strb;
    logic [DATA_W-1:0] req_wdata;
    logic              rsp_valid;
    logic [DATA_W-1:0] rsp_rdata;
    bad_t              rsp_bad;
    logic              rsp_xstate;

    // stimulus and expected response, one row per cycle
    string             t_name   [MAX_ENTRIES];
    logic              t_valid  [MAX_ENTRIES];
    logic [ADDR_W-1:0] t_addr   [MAX_ENTRIES];
    logic              t_write  [MAX_ENTRIES];
    logic              t_ex     [MAX_ENTRIES];
    logic [STRB_W-1:0] t_strb   [MAX_ENTRIES];
    logic [DATA_W-1:0] t_wdata  [MAX_ENTRIES];
    logic [DATA_W-1:0] t_rdata  [MAX_ENTRIES];
    bad_t              t_bad    [MAX_ENTRIES];
    logic              t_xstate [MAX_ENTRIES];

    logic [DATA_W-1:0] rom_img [ROM_WORDS];
    int                n_entries;
    int                n_issued;
    int                n_done;
    int                n_failed;
    int                pending [$];
    logic              table_ready;

    mem_subsys dut (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .req_valid  ( req_valid  ),
        .req_addr   ( req_addr   ),
        .req_write  ( req_write  ),
        .req_ex     ( req_ex     ),
        .req_strb   ( req_strb   ),
        .req_wdata  ( req_wdata  ),
        .rsp_valid  ( rsp_valid  ),
        .rsp_rdata  ( rsp_rdata  ),
        .rsp_bad    ( rsp_bad    ),
        .rsp_xstate ( rsp_xstate )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_row(input string name, input logic valid,
                           input logic [ADDR_W-1:0] addr, input logic write,
                           input logic ex, input logic [STRB_W-1:0] strb,
                           input logic [DATA_W-1:0] wdata,
                           input logic [DATA_W-1:0] rdata, input bad_t bad,
                           input logic xstate);
        t_name[n_entries]   = name;
        t_valid[n_entries]  = valid;
        t_addr[n_entries]   = addr;
        t_write[n_entries]  = write;
        t_ex[n_entries]     = ex;
        t_strb[n_entries]   = strb;
        t_wdata[n_entries]  = wdata;
        t_rdata[n_entries]  = rdata;
        t_bad[n_entries]    = bad;
        t_xstate[n_entries] = xstate;
        n_entries++;
    endtask

    task automatic add_read(input string name, input logic [ADDR_W-1:0] addr, input logic ex,
                            input logic [DATA_W-1:0] rdata, input bad_t bad);
        add_row(name, 1'b1, addr, 1'b0, ex, '0, '0, rdata, bad, 1'b0);
    endtask

    task automatic add_write(input string name, input logic [ADDR_W-1:0] addr,
                             input logic ex, input logic [STRB_W-1:0] strb,
                             input logic [DATA_W-1:0] wdata, input bad_t bad,
                             input logic xstate);
        // writes always return zero data
        add_row(name, 1'b1, addr, 1'b1, ex, strb, wdata, '0, bad, xstate);
    endtask

    task automatic add_idle();
        add_row("idle", 1'b0, '0, 1'b0, 1'b0, '0, '0, '0, 2'd0, 1'b0);
    endtask

    task automatic build_table();
        add_read("rom_rd_0", ROM_BASE, 1'b0, rom_img[0], 2'd0);
        add_read("rom_rd_5", ROM_BASE + 32'h14, 1'b0, rom_img[5], 2'd0);
        // low address bits ignored
        add_read("rom_rd_31", ROM_BASE + 32'h7E, 1'b0, rom_img[31], 2'd0);
        add_write("rom_wr_3", ROM_BASE + 32'hC, 1'b0, 4'hF, 32'hDEAD_BEEF, 2'd3, 1'b0);
        add_read("rom_rd_3", ROM_BASE + 32'hC, 1'b0, rom_img[3], 2'd0);
        add_idle();
        // write then read on the very next cycle
        add_write("sram_wr_a", SRAM_BASE + 32'h40, 1'b0, 4'hF, 32'h1234_5678, 2'd0, 1'b0);
        add_read("sram_rd_a", SRAM_BASE + 32'h40, 1'b0, 32'h1234_5678, 2'd0);
        add_write("sram_wr_full", SRAM_BASE + 32'h100, 1'b0, 4'hF, 32'hAABB_CCDD, 2'd0, 1'b0);
        add_write("sram_wr_part", SRAM_BASE + 32'h100, 1'b0, 4'b0101, 32'h1122_3344, 2'd0, 1'b0);
        add_read("sram_rd_merge", SRAM_BASE + 32'h100, 1'b0, 32'hAA22_CC44, 2'd0);
        add_idle();
        add_read("unmap_rd_lo", 32'h0000_0080, 1'b0, '0, 2'd2);
        add_write("unmap_wr", 32'h0002_0000, 1'b0, 4'hF, 32'h0BAD_0BAD, 2'd3, 1'b0);
        add_read("unmap_rd_hi", 32'hFFFF_FFF0, 1'b0, '0, 2'd2);
        add_idle();
        // exclusive pair, then a second store-conditional that must fail
        add_write("ex_init", SRAM_BASE + 32'h200, 1'b0, 4'hF, 32'h0000_0001, 2'd0, 1'b0);
        add_read("ex_rd", SRAM_BASE + 32'h200, 1'b1, 32'h0000_0001, 2'd0);
        add_write("ex_wr_ok", SRAM_BASE + 32'h200, 1'b1, 4'hF, 32'hC0FF_EE00, 2'd0, 1'b1);
        add_write("ex_wr_again", SRAM_BASE + 32'h200, 1'b1, 4'hF, 32'hBAD0_0BAD, 2'd0, 1'b0);
        add_read("ex_chk", SRAM_BASE + 32'h200, 1'b0, 32'hC0FF_EE00, 2'd0);
        add_idle();
        // plain store between the pair breaks the reservation
        add_write("ex2_init", SRAM_BASE + 32'h300, 1'b0, 4'hF, 32'h55AA_55AA, 2'd0, 1'b0);
        add_read("ex2_rd", SRAM_BASE + 32'h300, 1'b1, 32'h55AA_55AA, 2'd0);
        add_write("ex2_plain_wr", SRAM_BASE + 32'h300, 1'b0, 4'hF, 32'h600D_600D, 2'd0, 1'b0);
        add_write("ex2_wr_fail", SRAM_BASE + 32'h300, 1'b1, 4'hF, 32'hBAAD_F00D, 2'd0, 1'b0);
        add_read("ex2_chk", SRAM_BASE + 32'h300, 1'b0, 32'h600D_600D, 2'd0);
    endtask

    task automatic drive_row(input int i);
        req_valid = t_valid[i];
        req_addr  = t_addr[i];
        req_write = t_write[i];
        req_ex    = t_ex[i];
        req_strb  = t_strb[i];
        req_wdata = t_wdata[i];
        if (t_valid[i]) begin
            pending.push_back(i);
            n_issued++;
        end
    endtask

    task automatic check_response();
        int idx;
        bit ok;
        if (pending.size() == 0) begin
            $display("response arrived with no request outstanding");
            n_failed++;
        end else begin
            idx = pending.pop_front();
            ok  = 1'b1;
            assert (rsp_rdata === t_rdata[idx]) else begin
                $display("FAILED %s rdata expected %h actual %h",
                         t_name[idx], t_rdata[idx], rsp_rdata);
                ok = 1'b0;
            end
            assert (rsp_bad === t_bad[idx]) else begin
                $display("FAILED %s bad expected %0d actual %0d",
                         t_name[idx], t_bad[idx], rsp_bad);
                ok = 1'b0;
            end
            assert (rsp_xstate === t_xstate[idx]) else begin
                $display("FAILED %s xstate expected %0b actual %0b",
                         t_name[idx], t_xstate[idx], rsp_xstate);
                ok = 1'b0;
            end
            if (!ok) begin
                n_failed++;
            end
            $display("test %-14s %s", t_name[idx], ok ? "ok" : "mismatch");
            n_done++;
        end
    endtask

    // responses are stable away from the rising edge
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            check_response();
        end
    end

    initial begin
        wait (table_ready);
        #((n_entries + 20) * CLK_PERIOD);
        $display("timeout, responses still missing after %0d cycles", n_entries + 20);
        $display("Verification failed");
        $finish;
    end

    initial begin
        n_entries   = 0;
        n_issued    = 0;
        n_done      = 0;
        n_failed    = 0;
        table_ready = 1'b0;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_addr    = '0;
        req_write   = 1'b0;
        req_ex      = 1'b0;
        req_strb    = '0;
        req_wdata   = '0;
        $readmemh("hdl/boot_rom.hex", rom_img);
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            @(negedge clk);
            drive_row(i);
        end
        @(negedge clk);
        req_valid = 1'b0;
        while (n_done < n_issued) @(posedge clk);
        $display("tests %0d, passed %0d, failed %0d, assertion errors %0d",
                 n_done, n_done - n_failed, n_failed, dut.u_assertions.fail_count);
        if (n_failed == 0 && dut.u_assertions.fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/mem_subsys_assertions.sv ====
`default_nettype none

module mem_subsys_assertions (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 req_valid,
    input logic                 rsp_valid,
    input mem_access_pkg::bad_t rsp_bad,
    input logic                 rsp_xstate
);

    timeunit 1ns;
    timeprecision 100ps;

    // read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // synchronous reset clears the response on the next edge
    a_idle_in_reset: assert property (@(posedge clk) !rst_n |=> !rsp_valid)
        else begin
            $error("rsp_valid high after a reset edge");
            fail_count++;
        end

    // fixed two-cycle latency, one response per request
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid == $past(req_valid, 2))
        else begin
            $error("rsp_valid does not follow req_valid by two cycles");
            fail_count++;
        end

    a_xstate_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !rsp_valid |-> !rsp_xstate)
        else begin
            $error("rsp_xstate set without rsp_valid");
            fail_count++;
        end

    a_bad_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !rsp_valid |-> rsp_bad == 2'd0)
        else begin
            $error("rsp_bad nonzero without rsp_valid");
            fail_count++;
        end

endmodule

bind mem_subsys mem_subsys_assertions u_assertions (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .req_valid  ( req_valid  ),
    .rsp_valid  ( rsp_valid  ),
    .rsp_bad    ( rsp_bad    ),
    .rsp_xstate ( rsp_xstate )
);

`default_nettype wire

// ==== hdl/mem_subsys.sv ====
`default_nettype none

module mem_subsys (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req_valid,
    input  logic [mem_access_pkg::ADDR_W-1:0]   req_addr,
    input  logic                                req_write,
    input  logic                                req_ex,
    input  logic [mem_access_pkg::STRB_W-1:0]   req_strb,
    input  logic [mem_access_pkg::DATA_W-1:0]   req_wdata,
    output logic                                rsp_valid,
    output logic [mem_access_pkg::DATA_W-1:0]   rsp_rdata,
    output mem_access_pkg::bad_t                rsp_bad,
    output logic                                rsp_xstate
);

    import mem_map_pkg::*;
    import mem_access_pkg::*;

    // stage 1 contents
    logic               s1_valid;
    region_t            s1_region;
    logic [INDEX_W-1:0] s1_index;
    logic               s1_write;
    logic               s1_ex;
    logic [STRB_W-1:0]  s1_strb;
    logic [DATA_W-1:0]  s1_wdata;
    bad_t               s1_bad;
    logic               s1_excl_ok;

    addr_decode_stage u_decode (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .req_valid ( req_valid ),
        .req_addr  ( req_addr  ),
        .req_write ( req_write ),
        .req_ex    ( req_ex    ),
        .req_strb  ( req_strb  ),
        .req_wdata ( req_wdata ),
        .s1_valid  ( s1_valid  ),
        .s1_region ( s1_region ),
        .s1_index  ( s1_index  ),
        .s1_write  ( s1_write  ),
        .s1_ex     ( s1_ex     ),
        .s1_strb   ( s1_strb   ),
        .s1_wdata  ( s1_wdata  ),
        .s1_bad    ( s1_bad    )
    );

    excl_monitor u_xmon (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .s1_valid   ( s1_valid   ),
        .s1_region  ( s1_region  ),
        .s1_index   ( s1_index   ),
        .s1_write   ( s1_write   ),
        .s1_ex      ( s1_ex      ),
        .s1_bad     ( s1_bad     ),
        .s1_excl_ok ( s1_excl_ok )
    );

    mem_bank_stage u_bank (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .s1_valid   ( s1_valid   ),
        .s1_region  ( s1_region  ),
        .s1_index   ( s1_index   ),
        .s1_write   ( s1_write   ),
        .s1_ex      ( s1_ex      ),
        .s1_strb    ( s1_strb    ),
        .s1_wdata   ( s1_wdata   ),
        .s1_bad     ( s1_bad     ),
        .s1_excl_ok ( s1_excl_ok ),
        .rsp_valid  ( rsp_valid  ),
        .rsp_rdata  ( rsp_rdata  ),
        .rsp_bad    ( rsp_bad    ),
        .rsp_xstate ( rsp_xstate )
    );

endmodule

`default_nettype wire

// ==== hdl/mem_bank_stage.sv ====
`default_nettype none

module mem_bank_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                s1_valid,
    input  mem_map_pkg::region_t                s1_region,
    input  logic [mem_map_pkg::INDEX_W-1:0]     s1_index,
    input  logic                                s1_write,
    input  logic                                s1_ex,
    input  logic [mem_access_pkg::STRB_W-1:0]   s1_strb,
    input  logic [mem_access_pkg::DATA_W-1:0]   s1_wdata,
    input  mem_access_pkg::bad_t                s1_bad,
    input  logic                                s1_excl_ok,
    output logic                                rsp_valid,
    output logic [mem_access_pkg::DATA_W-1:0]   rsp_rdata,
    output mem_access_pkg::bad_t                rsp_bad,
    output logic                                rsp_xstate
);

    import mem_map_pkg::*;
    import mem_access_pkg::*;

    logic [DATA_W-1:0] rom [ROM_WORDS];
    logic [DATA_W-1:0] rom_rdata;
    logic [DATA_W-1:0] sram_rdata;
    logic              access_ok;
    logic              rom_rd;
    logic              sram_cs;
    logic              rd_q;
    region_t           region_q;

    initial begin
        $readmemh(ROM_FILE, rom);
    end

    assign access_ok = s1_valid && s1_bad == BAD_OK;
    assign rom_rd    = access_ok && s1_region == REGION_ROM && !s1_write;
    // failed store-conditional leaves the SRAM untouched
    assign sram_cs   = access_ok && s1_region == REGION_SRAM && (!(s1_write && s1_ex) || s1_excl_ok);

    always_ff @(posedge clk) begin
        if (rom_rd) begin
            rom_rdata <= rom[s1_index[ROM_INDEX_W-1:0]];
        end
    end

    sram_bank #(
        .DEPTH ( SRAM_WORDS )
    ) u_sram (
        .clk   ( clk        ),
        .cs    ( sram_cs    ),
        .we    ( s1_write   ),
        .index ( s1_index   ),
        .strb  ( s1_strb    ),
        .wdata ( s1_wdata   ),
        .rdata ( sram_rdata )
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid  <= 1'b0;
            rsp_bad    <= BAD_OK;
            rsp_xstate <= 1'b0;
            rd_q       <= 1'b0;
            region_q   <= REGION_NONE;
        end else begin
            rsp_valid  <= s1_valid;
            rsp_bad    <= s1_valid ? s1_bad : BAD_OK;
            rsp_xstate <= s1_excl_ok;
            rd_q       <= s1_valid && !s1_write;
            region_q   <= s1_region;
        end
    end

    // writes and faults return zero
    always_comb begin
        rsp_rdata = '0;
        if (rd_q && rsp_bad == BAD_OK) begin
            case (region_q)
                REGION_ROM:  rsp_rdata = rom_rdata;
                REGION_SRAM: rsp_rdata = sram_rdata;
                default:     rsp_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/excl_monitor.sv ====
`default_nettype none

module excl_monitor (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            s1_valid,
    input  mem_map_pkg::region_t            s1_region,
    input  logic [mem_map_pkg::INDEX_W-1:0] s1_index,
    input  logic                            s1_write,
    input  logic                            s1_ex,
    input  mem_access_pkg::bad_t            s1_bad,
    output logic                            s1_excl_ok
);

    import mem_map_pkg::*;
    import mem_access_pkg::*;

    logic               res_valid;
    region_t            res_region;
    logic [INDEX_W-1:0] res_index;
    logic               res_match;

    assign res_match = res_valid && res_region == s1_region && res_index == s1_index;

    // store-conditional pass, a faulting store never passes
    assign s1_excl_ok = s1_valid && s1_write && s1_ex && s1_bad == BAD_OK && res_match;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (s1_valid) begin
            if (s1_write && s1_ex) begin
                // any store-conditional drops the reservation
                res_valid <= 1'b0;
            end else if (s1_bad == BAD_OK) begin
                if (s1_ex) begin
                    res_valid <= 1'b1;
                end else if (s1_write && res_match) begin
                    res_valid <= 1'b0;
                end
            end
        end
    end

    // reserved word, only meaningful while res_valid is set
    always_ff @(posedge clk) begin
        if (s1_valid && s1_ex && !s1_write && s1_bad == BAD_OK) begin
            res_region <= s1_region;
            res_index  <= s1_index;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/addr_decode_stage.sv ====
`default_nettype none

module addr_decode_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                req_valid,
    input  logic [mem_access_pkg::ADDR_W-1:0]   req_addr,
    input  logic                                req_write,
    input  logic                                req_ex,
    input  logic [mem_access_pkg::STRB_W-1:0]   req_strb,
    input  logic [mem_access_pkg::DATA_W-1:0]   req_wdata,
    output logic                                s1_valid,
    output mem_map_pkg::region_t                s1_region,
    output logic [mem_map_pkg::INDEX_W-1:0]     s1_index,
    output logic                                s1_write,
    output logic                                s1_ex,
    output logic [mem_access_pkg::STRB_W-1:0]   s1_strb,
    output logic [mem_access_pkg::DATA_W-1:0]   s1_wdata,
    output mem_access_pkg::bad_t                s1_bad
);

    import mem_map_pkg::*;
    import mem_access_pkg::*;

    logic [ADDR_W-1:0]  rom_off;
    logic [ADDR_W-1:0]  sram_off;
    region_t            region;
    logic [INDEX_W-1:0] index;
    bad_t               bad;

    // offsets wrap below the base, so one compare covers both ends
    assign rom_off  = req_addr - ROM_BASE;
    assign sram_off = req_addr - SRAM_BASE;

    always_comb begin
        region = REGION_NONE;
        index  = '0;
        if (rom_off < ADDR_W'(ROM_WORDS * 4)) begin
            region = REGION_ROM;
            index  = rom_off[2 +: INDEX_W];
        end else if (sram_off < ADDR_W'(SRAM_WORDS * 4)) begin
            region = REGION_SRAM;
            index  = sram_off[2 +: INDEX_W];
        end
    end

    always_comb begin
        if (region == REGION_NONE) begin
            bad = req_write ? BAD_STORE : BAD_LOAD;
        end else if (region == REGION_ROM && req_write) begin
            bad = BAD_STORE;
        end else begin
            bad = BAD_OK;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    // payload only moves with a request
    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_region <= region;
            s1_index  <= index;
            s1_write  <= req_write;
            s1_ex     <= req_ex;
            s1_strb   <= req_strb;
            s1_wdata  <= req_wdata;
            s1_bad    <= bad;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/sram_bank.sv ====
`default_nettype none

module sram_bank #(
    parameter int DEPTH = mem_map_pkg::SRAM_WORDS
) (
    input  logic                              clk,
    input  logic                              cs,
    input  logic                              we,
    input  logic [$clog2(DEPTH)-1:0]          index,
    input  logic [mem_access_pkg::STRB_W-1:0] strb,
    input  logic [mem_access_pkg::DATA_W-1:0] wdata,
    output logic [mem_access_pkg::DATA_W-1:0] rdata
);

    import mem_access_pkg::*;

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (we) begin
                // byte lanes
                for (int b = 0; b < STRB_W; b++) begin
                    if (strb[b]) begin
                        mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[index];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_access_pkg.sv ====
`default_nettype none

package mem_access_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // one strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;

    // response fault code, same encoding as dmem_bad on the core
    typedef logic [1:0] bad_t;

    localparam bad_t BAD_OK    = 2'd0;
    // unmapped read
    localparam bad_t BAD_LOAD  = 2'd2;
    // unmapped write or any write to ROM
    localparam bad_t BAD_STORE = 2'd3;

endpackage

`default_nettype wire

// ==== hdl/mem_map_pkg.sv ====
`default_nettype none

package mem_map_pkg;

    // boot ROM window
    localparam logic [31:0] ROM_BASE  = 32'h0000_0000;
    localparam int          ROM_WORDS = 32;

    // on-chip SRAM window
    localparam logic [31:0] SRAM_BASE  = 32'h0001_0000;
    localparam int          SRAM_WORDS = 1024;

    // word index widths, the SRAM is the deeper of the two
    localparam int ROM_INDEX_W = $clog2(ROM_WORDS);
    localparam int INDEX_W     = $clog2(SRAM_WORDS);

    // ROM image, one 32-bit hex word per line
    localparam string ROM_FILE = "hdl/boot_rom.hex";

    typedef enum logic [1:0] {
        REGION_ROM  = 2'd0,
        REGION_SRAM = 2'd1,
        REGION_NONE = 2'd2
    } region_t;

endpackage

`default_nettype wire
